// File: verilog/uart_pkg.sv
/*
 * Serial line definitions for the UART.
 * Baud divisor, oversampling ratio, counter widths,
 * the data byte type and the transmitter and receiver state encodings.
 */
package uart_pkg;

    localparam int unsigned BAUD_DIV   = 64;                    // system clocks per bit.
    localparam int unsigned OVERSAMPLE = 16;                    // receiver samples per bit.
    localparam int unsigned OS_DIV     = BAUD_DIV / OVERSAMPLE; // clocks per sample tick.
    localparam int unsigned DATA_BITS  = 8;

    // counter widths derived from the ratios above.
    localparam int unsigned BAUD_CNT_W = $clog2(BAUD_DIV);
    localparam int unsigned OS_CNT_W   = $clog2(OS_DIV);
    localparam int unsigned SMP_CNT_W  = $clog2(OVERSAMPLE);
    localparam int unsigned BIT_CNT_W  = $clog2(DATA_BITS + 1);

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,  // byte latched, waiting for the next bit tick.
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,  // falling edge seen, qualifying at mid start bit.
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

// File: verilog/wb_regs_pkg.sv
/*
 * Bus side definitions for the UART peripheral.
 * Address and data types, the register map and the status bit positions.
 */
package wb_regs_pkg;

    localparam int unsigned ADDR_W = 2;
    localparam int unsigned DATA_W = 8;

    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [DATA_W-1:0] wb_data_t;

    // register map, one byte per address.
    localparam wb_addr_t TX_REG  = wb_addr_t'(0);  // write starts a transmission.
    localparam wb_addr_t RX_REG  = wb_addr_t'(1);  // last received byte.
    localparam wb_addr_t CTL_REG = wb_addr_t'(2);  // status, error bits are write one to clear.

    // bit positions inside the CTL register.
    localparam int unsigned ST_TX_BUSY    = 0;
    localparam int unsigned ST_RX_VALID   = 1;
    localparam int unsigned ST_RX_OVERRUN = 2;
    localparam int unsigned ST_FRAME_ERR  = 3;

endpackage

// File: verilog/baud_gen.sv
/*
 * Baud rate generator.
 * Produces a one-cycle enable at the bit rate and one at the
 * oversampling rate, both derived from the system clock.
 */
`timescale 1ns/1ps

module baud_gen (
    input  logic clk,
    input  logic i_rst,
    output logic o_bit_tick,
    output logic o_sample_tick
);
    import uart_pkg::*;

    logic [BAUD_CNT_W-1:0] bit_cnt;
    logic [OS_CNT_W-1:0]   os_cnt;

    // both counters start from their top value, so the bit tick always
    // lands on a sample tick.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            bit_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
            os_cnt  <= OS_CNT_W'(OS_DIV - 1);
        end else begin
            if (bit_cnt == '0) begin
                bit_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);  // reload at end of bit period.
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end

            if (os_cnt == '0) begin
                os_cnt <= OS_CNT_W'(OS_DIV - 1);
            end else begin
                os_cnt <= os_cnt - 1'b1;
            end
        end
    end

    assign o_bit_tick    = (bit_cnt == '0);
    assign o_sample_tick = (os_cnt == '0);

    // the two rates must stay phase aligned.
    a_bit_on_sample: assert property (
        @(posedge clk) disable iff (i_rst) o_bit_tick |-> o_sample_tick
    );

endmodule

// File: verilog/uart_tx.sv
/*
 * UART transmitter.
 * Sends one 8N1 frame per start request, start bit first,
 * then the data bits LSB first and a single stop bit.
 */
`timescale 1ns/1ps

module uart_tx (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_bit_tick,
    input  logic                i_start,
    input  uart_pkg::uart_byte_t i_data,
    output logic                o_busy,
    output logic                o_tx
);
    import uart_pkg::*;

    tx_state_t            state;
    uart_byte_t           shreg;    // bits still to be sent, LSB next.
    logic [BIT_CNT_W-1:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            o_tx    <= 1'b1;  // line idles high.
        end else begin
            case (state)
                TX_IDLE: begin
                    o_tx <= 1'b1;
                    if (i_start) begin
                        state <= TX_START;
                    end
                end

                // hold the line high until the bit grid comes round.
                TX_START: begin
                    if (i_bit_tick) begin
                        o_tx    <= 1'b0;  // start bit.
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                    end
                end

                TX_DATA: begin
                    if (i_bit_tick) begin
                        if (bit_cnt == BIT_CNT_W'(DATA_BITS)) begin
                            o_tx  <= 1'b1;  // all data bits out, drive the stop bit.
                            state <= TX_STOP;
                        end else begin
                            o_tx    <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                TX_STOP: begin
                    if (i_bit_tick) begin
                        state <= TX_IDLE;  // stop bit has lasted one full bit time.
                    end
                end

                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // data path, loaded on an accepted start and shifted on each data bit.
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && i_start) begin
            shreg <= i_data;
        end else if (state == TX_DATA && i_bit_tick &&
                     bit_cnt != BIT_CNT_W'(DATA_BITS)) begin
            shreg <= shreg >> 1;
        end
    end

    assign o_busy = (state != TX_IDLE);

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (i_rst) (state == TX_IDLE) |-> o_tx
    );

endmodule

// File: verilog/uart_rx.sv
/*
 * UART receiver.
 * Synchronizes the serial input, qualifies the start bit at mid-bit,
 * samples each data bit in its middle with 16x oversampling and
 * checks the stop bit.
 */
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_sample_tick,
    input  logic                 i_rx,
    output logic                 o_strobe,
    output uart_pkg::uart_byte_t o_data,
    output logic                 o_frame_err
);
    import uart_pkg::*;

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;   // previous synchronized level, for edge detection.
    logic                 rx_fall;
    rx_state_t            state;
    logic [SMP_CNT_W-1:0] smp_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    uart_byte_t           shreg;

    // two-flop synchronizer, the line is asynchronous to clk.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign rx_fall = rx_prev & ~rx_sync;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state       <= RX_IDLE;
            smp_cnt     <= '0;
            bit_cnt     <= '0;
            o_strobe    <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            o_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_fall) begin
                        smp_cnt <= '0;
                        state   <= RX_START;
                    end
                end

                RX_START: begin
                    if (i_sample_tick) begin
                        if (smp_cnt == SMP_CNT_W'(OVERSAMPLE / 2 - 1)) begin
                            // mid start bit, a high line here was a glitch.
                            smp_cnt <= '0;
                            bit_cnt <= '0;
                            state   <= rx_sync ? RX_IDLE : RX_DATA;
                        end else begin
                            smp_cnt <= smp_cnt + 1'b1;
                        end
                    end
                end

                RX_DATA: begin
                    if (i_sample_tick) begin
                        if (smp_cnt == SMP_CNT_W'(OVERSAMPLE - 1)) begin
                            smp_cnt <= '0;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
                                state <= RX_STOP;
                            end
                        end else begin
                            smp_cnt <= smp_cnt + 1'b1;
                        end
                    end
                end

                RX_STOP: begin
                    if (i_sample_tick) begin
                        if (smp_cnt == SMP_CNT_W'(OVERSAMPLE - 1)) begin
                            o_strobe    <= 1'b1;      // byte complete.
                            o_frame_err <= ~rx_sync;  // stop bit must be high.
                            state       <= RX_IDLE;
                        end else begin
                            smp_cnt <= smp_cnt + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // shift register fills from the top, so the first bit ends up in bit 0.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && i_sample_tick && smp_cnt == SMP_CNT_W'(OVERSAMPLE - 1)) begin
            shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
        end
    end

    assign o_data = shreg;

    a_strobe_single: assert property (
        @(posedge clk) disable iff (i_rst) o_strobe |=> !o_strobe
    );

endmodule

// File: verilog/wb_uart.sv
/*
 * Wishbone UART peripheral, top level.
 * Classic pipelined single cycle slave with TX, RX and CTL registers,
 * the receive holding register, sticky status flags, and the
 * baud generator, transmitter and receiver instances.
 */
`timescale 1ns/1ps

module wb_uart (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  wb_regs_pkg::wb_addr_t i_wb_addr,
    input  wb_regs_pkg::wb_data_t i_wb_data,
    output logic                  o_wb_ack,
    output logic                  o_wb_stall,
    output wb_regs_pkg::wb_data_t o_wb_data,
    input  logic                  i_uart_rx,
    output logic                  o_uart_tx
);
    import uart_pkg::*;
    import wb_regs_pkg::*;

    logic       bit_tick;
    logic       sample_tick;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    logic       rx_strobe;
    uart_byte_t rx_data;
    logic       rx_frame_err;

    logic       wb_req;
    logic       rd_rx;      // bus read of the RX register this cycle.
    logic       wr_ctl;
    logic       rx_pend;    // strobe delayed by one cycle.
    logic       rx_pend_ferr;
    uart_byte_t rx_hold;
    logic       rx_valid;
    logic       rx_overrun;
    logic       frame_err;
    wb_data_t   status;
    wb_data_t   rd_mux;

    assign o_wb_stall = 1'b0;  // every request is taken at once.
    assign wb_req     = i_wb_cyc & i_wb_stb;
    assign rd_rx      = wb_req & ~i_wb_we & (i_wb_addr == RX_REG);
    assign wr_ctl     = wb_req & i_wb_we & (i_wb_addr == CTL_REG);

    // a write while busy is acknowledged but the byte goes nowhere.
    assign tx_start = wb_req & i_wb_we & (i_wb_addr == TX_REG) & ~tx_busy;
    assign tx_data  = i_wb_data;

    always_comb begin
        status                = '0;
        status[ST_TX_BUSY]    = tx_busy;
        status[ST_RX_VALID]   = rx_valid;
        status[ST_RX_OVERRUN] = rx_overrun;
        status[ST_FRAME_ERR]  = frame_err;
    end

    always_comb begin
        case (i_wb_addr)
            RX_REG:  rd_mux = rx_hold;
            CTL_REG: rd_mux = status;
            default: rd_mux = '0;  // TX and the unused address read as zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_req;
        end
    end

    // read data lines up with the ack. writes return zero.
    always_ff @(posedge clk) begin
        o_wb_data <= (wb_req && !i_wb_we) ? rd_mux : '0;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rx_pend      <= 1'b0;
            rx_pend_ferr <= 1'b0;
            rx_valid     <= 1'b0;
            rx_overrun   <= 1'b0;
            frame_err    <= 1'b0;
        end else begin
            rx_pend      <= rx_strobe;
            rx_pend_ferr <= rx_strobe & rx_frame_err;

            if (rx_pend) begin
                rx_valid <= 1'b1;  // a new byte wins over a read in the same cycle.
            end else if (rd_rx) begin
                rx_valid <= 1'b0;
            end

            if (rx_pend && rx_valid && !rd_rx) begin
                rx_overrun <= 1'b1;  // previous byte was never read.
            end else if (wr_ctl && i_wb_data[ST_RX_OVERRUN]) begin
                rx_overrun <= 1'b0;
            end

            if (rx_pend_ferr) begin
                frame_err <= 1'b1;
            end else if (wr_ctl && i_wb_data[ST_FRAME_ERR]) begin
                frame_err <= 1'b0;
            end
        end
    end

    // receiver data stays put until the next frame starts shifting.
    always_ff @(posedge clk) begin
        if (rx_pend) begin
            rx_hold <= rx_data;
        end
    end

    baud_gen baud_gen_inst (
        .clk           (clk),
        .i_rst         (i_rst),
        .o_bit_tick    (bit_tick),
        .o_sample_tick (sample_tick)
    );

    uart_tx uart_tx_inst (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_bit_tick (bit_tick),
        .i_start    (tx_start),
        .i_data     (tx_data),
        .o_busy     (tx_busy),
        .o_tx       (o_uart_tx)
    );

    uart_rx uart_rx_inst (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_sample_tick (sample_tick),
        .i_rx          (i_uart_rx),
        .o_strobe      (rx_strobe),
        .o_data        (rx_data),
        .o_frame_err   (rx_frame_err)
    );

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (i_rst) o_wb_ack |-> $past(wb_req)
    );

endmodule

// File: bench/uart_checker.sv
/*
 * Testbench checker for the Wishbone UART.
 * Checks ack timing, stall and read data of every bus request, decodes the
 * transmit line at mid-bit and compares each byte with the expected queue.
 */
`timescale 1ns/1ps

module uart_checker (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_ack,
    input  logic                  i_wb_stall,
    input  wb_regs_pkg::wb_data_t i_wb_data,
    input  logic                  i_uart_tx,
    input  logic                  i_exp_valid,
    input  wb_regs_pkg::wb_data_t i_exp_value,
    input  wb_regs_pkg::wb_data_t i_exp_mask,
    input  logic                  i_tx_exp_valid,
    input  uart_pkg::uart_byte_t  i_tx_exp_value,
    input  logic [127:0]          i_test_name,
    output int                    o_errors,
    output int                    o_rd_checks,
    output int                    o_tx_checks,
    output int                    o_acks,
    output int                    o_tx_pending
);
    import uart_pkg::*;
    import wb_regs_pkg::*;

    uart_byte_t   exp_q[$];   // bytes that writes to TX have promised.
    logic [127:0] name_q[$];
    uart_byte_t   exp_byte;
    logic [127:0] exp_name;
    logic         req_prev;
    logic         line_prev;
    uart_byte_t   line_byte;
    logic         stop_bit;
    int           i;

    initial begin
        o_errors     = 0;
        o_rd_checks  = 0;
        o_tx_checks  = 0;
        o_acks       = 0;
        o_tx_pending = 0;
        req_prev     = 1'b0;
        line_prev    = 1'b1;
    end

    // each ack must follow a request by exactly one cycle.
    always @(posedge clk) begin
        if (i_rst) begin
            req_prev <= 1'b0;
        end else begin
            if (i_wb_stall !== 1'b0) begin
                o_errors = o_errors + 1;
                $display("Mismatch %0s: expected stall 0, actual %b", i_test_name, i_wb_stall);
            end
            if (i_wb_ack !== req_prev) begin
                o_errors = o_errors + 1;
                $display("bus error at %0t: ack was %b but the request one cycle before was %b",
                         $time, i_wb_ack, req_prev);
            end
            if (i_wb_ack === 1'b1) begin
                o_acks = o_acks + 1;
            end
            if (i_wb_ack === 1'b1 && i_exp_valid) begin
                o_rd_checks = o_rd_checks + 1;
                if ((i_wb_data & i_exp_mask) !== i_exp_value) begin
                    o_errors = o_errors + 1;
                    $display("Mismatch %0s: expected 0x%02h, actual 0x%02h",
                             i_test_name, i_exp_value, i_wb_data & i_exp_mask);
                end
            end
            req_prev <= i_wb_cyc & i_wb_stb;
        end
    end

    always @(posedge clk) begin
        if (!i_rst && i_tx_exp_valid) begin
            exp_q.push_back(i_tx_exp_value);
            name_q.push_back(i_test_name);
            o_tx_pending = exp_q.size();
        end
    end

    // line decoder, the start edge is seen at most one cycle late.
    always begin
        @(posedge clk);
        if (!i_rst && line_prev === 1'b1 && i_uart_tx === 1'b0) begin
            repeat (BAUD_DIV / 2) @(posedge clk);
            if (i_uart_tx !== 1'b0) begin
                o_errors = o_errors + 1;
                $display("start bit on the transmit line did not last until mid-bit");
            end
            for (i = 0; i < 8; i = i + 1) begin
                repeat (BAUD_DIV) @(posedge clk);
                line_byte[i] = i_uart_tx;  // data arrives LSB first.
            end
            repeat (BAUD_DIV) @(posedge clk);
            stop_bit    = i_uart_tx;
            o_tx_checks = o_tx_checks + 1;
            if (stop_bit !== 1'b1) begin
                o_errors = o_errors + 1;
                $display("stop bit on the transmit line was not high");
            end
            if (exp_q.size() == 0) begin
                o_errors = o_errors + 1;
                $display("byte 0x%02h was sent on the line although no write expected it",
                         line_byte);
            end else begin
                exp_byte     = exp_q.pop_front();
                exp_name     = name_q.pop_front();
                o_tx_pending = exp_q.size();
                if (line_byte !== exp_byte) begin
                    o_errors = o_errors + 1;
                    $display("Mismatch %0s: expected 0x%02h, actual 0x%02h",
                             exp_name, exp_byte, line_byte);
                end
            end
        end
        line_prev = i_uart_tx;
    end

endmodule

// File: bench/tb_wb_uart.sv
/*
 * Testbench top for the Wishbone UART.
 * Clock and reset, stimulus file reader, bus and serial line tasks,
 * status polling, watchdog and the closing report.
 */
`timescale 1ns/1ps

module tb_wb_uart;
    import uart_pkg::*;
    import wb_regs_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_OPS    = 64;
    localparam int ACK_LIMIT  = 8;
    localparam int POLL_LIMIT = 12 * BAUD_DIV;  // two polling cycles each, well over a frame.

    logic         clk;
    logic         i_rst;
    logic         i_wb_cyc;
    logic         i_wb_stb;
    logic         i_wb_we;
    wb_addr_t     i_wb_addr;
    wb_data_t     i_wb_data;
    logic         o_wb_ack;
    logic         o_wb_stall;
    wb_data_t     o_wb_data;
    logic         i_uart_rx;
    logic         o_uart_tx;

    logic         exp_valid;
    wb_data_t     exp_value;
    wb_data_t     exp_mask;
    logic         tx_exp_valid;
    uart_byte_t   tx_exp_value;
    logic [127:0] test_name;
    int           err_count;
    int           rd_checks;
    int           tx_checks;
    int           ack_count;
    int           tx_pending;

    logic [127:0] op_name [MAX_OPS];
    logic [31:0]  op_kind [MAX_OPS];
    wb_addr_t     op_addr [MAX_OPS];
    wb_data_t     op_data [MAX_OPS];
    wb_data_t     op_exp  [MAX_OPS];
    int           n_ops;
    logic         loaded;
    int           bench_errors;
    int           req_count;
    int           op_idx;
    int           total;

    wb_uart wb_uart_inst (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_addr  (i_wb_addr),
        .i_wb_data  (i_wb_data),
        .o_wb_ack   (o_wb_ack),
        .o_wb_stall (o_wb_stall),
        .o_wb_data  (o_wb_data),
        .i_uart_rx  (i_uart_rx),
        .o_uart_tx  (o_uart_tx)
    );

    uart_checker uart_checker_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_ack       (o_wb_ack),
        .i_wb_stall     (o_wb_stall),
        .i_wb_data      (o_wb_data),
        .i_uart_tx      (o_uart_tx),
        .i_exp_valid    (exp_valid),
        .i_exp_value    (exp_value),
        .i_exp_mask     (exp_mask),
        .i_tx_exp_valid (tx_exp_valid),
        .i_tx_exp_value (tx_exp_value),
        .i_test_name    (test_name),
        .o_errors       (err_count),
        .o_rd_checks    (rd_checks),
        .o_tx_checks    (tx_checks),
        .o_acks         (ack_count),
        .o_tx_pending   (tx_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_stimulus();
        int           fd;
        int           cnt;
        string        line;
        logic [127:0] name;
        logic [31:0]  kind;
        wb_addr_t     addr;
        wb_data_t     data;
        wb_data_t     exp;
        fd = $fopen("bench/uart_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/uart_stim.txt");
            bench_errors = bench_errors + 1;
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments.
                    cnt = $sscanf(line, "%s %s %h %h %h", name, kind, addr, data, exp);
                    if (cnt == 5) begin
                        op_name[n_ops] = name;
                        op_kind[n_ops] = kind;
                        op_addr[n_ops] = addr;
                        op_data[n_ops] = data;
                        op_exp[n_ops]  = exp;
                        n_ops          = n_ops + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one single-cycle request, then wait for its ack.
    task automatic bus_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                              input logic check, input wb_data_t exp, input wb_data_t mask,
                              input logic push_tx, output wb_data_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        i_wb_cyc     = 1'b1;
        i_wb_stb     = 1'b1;
        i_wb_we      = we;
        i_wb_addr    = addr;
        i_wb_data    = wdata;
        exp_valid    = check;  // held until the checker has seen the ack.
        exp_value    = exp;
        exp_mask     = mask;
        tx_exp_valid = push_tx;
        tx_exp_value = wdata;
        req_count    = req_count + 1;
        @(negedge clk);
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_data    = '0;
        tx_exp_valid = 1'b0;
        while (o_wb_ack !== 1'b1 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (o_wb_ack !== 1'b1) begin
            $display("%0s: no ack within %0d cycles of the request", test_name, ACK_LIMIT);
            bench_errors = bench_errors + 1;
        end
        rdata = o_wb_data;
    endtask

    task automatic poll_status(input wb_addr_t addr, input wb_data_t mask, input wb_data_t exp);
        wb_data_t rdata;
        int       polls;
        polls = 0;
        do begin
            bus_access(1'b0, addr, '0, 1'b0, '0, '0, 1'b0, rdata);
            polls = polls + 1;
        end while ((rdata & mask) != exp && polls < POLL_LIMIT);
        if ((rdata & mask) != exp) begin
            $display("%0s: register %0d did not reach 0x%02h under mask 0x%02h in time",
                     test_name, addr, exp, mask);
            bench_errors = bench_errors + 1;
        end
    endtask

    // 8N1 frame on the receive line followed by one idle bit.
    task automatic send_serial(input uart_byte_t value, input logic bad_stop);
        int i;
        @(negedge clk);
        exp_valid = 1'b0;
        i_uart_rx = 1'b0;
        repeat (BAUD_DIV) @(negedge clk);
        for (i = 0; i < 8; i = i + 1) begin
            i_uart_rx = value[i];
            repeat (BAUD_DIV) @(negedge clk);
        end
        i_uart_rx = ~bad_stop;
        repeat (BAUD_DIV) @(negedge clk);
        i_uart_rx = 1'b1;
        repeat (BAUD_DIV) @(negedge clk);
    endtask

    task automatic run_op(input int k);
        wb_data_t rdata;
        test_name = op_name[k];
        case (op_kind[k])
            "WR": bus_access(1'b1, op_addr[k], op_data[k], 1'b0, '0, '0,
                             op_addr[k] == TX_REG && op_exp[k] == 8'h01, rdata);
            "RD": bus_access(1'b0, op_addr[k], '0, 1'b1, op_exp[k], op_data[k], 1'b0, rdata);
            "SER": send_serial(op_data[k], op_exp[k][0]);
            "WAIT": poll_status(op_addr[k], op_data[k], op_exp[k]);
            default: begin
                $display("%0s: unknown operation in the stimulus file", test_name);
                bench_errors = bench_errors + 1;
            end
        endcase
    endtask

    initial begin
        i_rst        = 1'b1;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_addr    = '0;
        i_wb_data    = '0;
        i_uart_rx    = 1'b1;
        exp_valid    = 1'b0;
        exp_value    = '0;
        exp_mask     = '0;
        tx_exp_valid = 1'b0;
        tx_exp_value = '0;
        test_name    = "reset";
        bench_errors = 0;
        req_count    = 0;
        n_ops        = 0;
        loaded       = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (3) @(posedge clk);  // reset spans three rising edges.
        @(negedge clk);
        i_rst = 1'b0;
        for (op_idx = 0; op_idx < n_ops; op_idx = op_idx + 1) begin
            run_op(op_idx);
        end
        repeat (2) @(negedge clk);  // let the checker see the last ack.
        if (tx_pending != 0) begin
            $display("%0d expected byte(s) never appeared on the transmit line", tx_pending);
            bench_errors = bench_errors + 1;
        end
        if (req_count != ack_count) begin
            $display("%0d requests were issued but %0d acks seen", req_count, ack_count);
            bench_errors = bench_errors + 1;
        end
        total = err_count + bench_errors;
        $display("errors: %0d (checker %0d, bench %0d), reads: %0d, bytes: %0d, acks: %0d",
                 total, err_count, bench_errors, rd_checks, tx_checks, ack_count);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // twelve frame times per stimulus line.
    initial begin
        wait (loaded);
        #(longint'(n_ops + 1) * 12 * 10 * BAUD_DIV * CLK_PERIOD);
        $display("watchdog expired at %0t, the stimulus did not complete", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: bench/uart_stim.txt
# columns: name op addr data exp, all numbers hex. WR exp 1 means the byte must go out on the line.
# RD and WAIT compare (read & data) with exp. SER sends data on the line, exp 1 gives a low stop.
tx_basic   WR   0 a5 01
tx_busy    RD   2 01 01
tx_done    WAIT 2 01 00
tx_first   WR   0 3c 01
tx_drop    WR   0 c3 00
tx_poll    WAIT 2 01 00
tx_second  WR   0 81 01
tx_idle    WAIT 2 01 00
rx_send    SER  0 5a 00
rx_poll    WAIT 2 02 02
rx_data    RD   1 ff 5a
rx_clear   RD   2 02 00
ovr_byte1  SER  0 11 00
ovr_byte2  SER  0 e7 00
ovr_poll   WAIT 2 06 06
ovr_data   RD   1 ff e7
ovr_clear  WR   2 04 00
ovr_check  RD   2 06 00
ferr_send  SER  0 96 01
ferr_poll  WAIT 2 0a 0a
ferr_data  RD   1 ff 96
ferr_clear WR   2 08 00
ferr_check RD   2 ff 00
unused_rd  RD   3 ff 00

// File: src.f
verilog/uart_pkg.sv
verilog/wb_regs_pkg.sv
verilog/baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/wb_uart.sv
bench/uart_checker.sv
bench/tb_wb_uart.sv

// File: Bender.yml
package:
  name: wb_uart

sources:
  # packages first, every module imports them.
  - verilog/uart_pkg.sv
  - verilog/wb_regs_pkg.sv
  - verilog/baud_gen.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/wb_uart.sv
  - target: simulation
    files:
      - bench/uart_checker.sv
      - bench/tb_wb_uart.sv
